/* hw/video_axil_slave.sv */
`include "video_macros.svh"

module video_axil_slave (
    input  logic                  clk_cpu_i,
    input  logic                  rst_n_i,

    input  video_pkg::byte_addr_t s_axil_awaddr_i,
    input  logic                  s_axil_awvalid_i,
    output logic                  s_axil_awready_o,

    input  video_pkg::word_t      s_axil_wdata_i,
    input  video_pkg::strb_t      s_axil_wstrb_i,
    input  logic                  s_axil_wvalid_i,
    output logic                  s_axil_wready_o,

    output video_pkg::resp_t      s_axil_bresp_o,
    output logic                  s_axil_bvalid_o,
    input  logic                  s_axil_bready_i,

    input  video_pkg::byte_addr_t s_axil_araddr_i,
    input  logic                  s_axil_arvalid_i,
    output logic                  s_axil_arready_o,

    output video_pkg::word_t      s_axil_rdata_o,
    output video_pkg::resp_t      s_axil_rresp_o,
    output logic                  s_axil_rvalid_o,
    input  logic                  s_axil_rready_i,

    output video_pkg::word_addr_t ram_addr_o,
    output video_pkg::word_t      ram_wdata_o,
    output video_pkg::strb_t      ram_wstrb_o,
    output logic                  ram_rd_en_o,
    input  video_pkg::word_t      ram_rdata_i
);

    video_pkg::axil_wr_state_t wr_state_q;
    video_pkg::axil_rd_state_t rd_state_q;
    video_pkg::word_t          rdata_q;
    logic                      wr_accept;
    logic                      rd_accept;

    // address and data are taken together, one write per response
    assign wr_accept = (wr_state_q == video_pkg::WR_IDLE) && s_axil_awvalid_i &&
                       s_axil_wvalid_i;

    // write owns the shared ram port when both arrive
    assign rd_accept = (rd_state_q == video_pkg::RD_IDLE) && s_axil_arvalid_i && !wr_accept;

    assign s_axil_awready_o = wr_accept;
    assign s_axil_wready_o  = wr_accept;
    assign s_axil_arready_o = rd_accept;

    // shared cpu port of the ram
    assign ram_addr_o  = wr_accept ? s_axil_awaddr_i[11:2] : s_axil_araddr_i[11:2];
    assign ram_wdata_o = s_axil_wdata_i;
    assign ram_wstrb_o = wr_accept ? s_axil_wstrb_i : '0;
    assign ram_rd_en_o = rd_accept;

    always_ff @(posedge clk_cpu_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_state_q <= video_pkg::WR_IDLE;
        end else begin
            case (wr_state_q)
                video_pkg::WR_IDLE: begin
                    if (wr_accept) begin
                        wr_state_q <= video_pkg::WR_RESP;
                    end
                end
                video_pkg::WR_RESP: begin
                    if (s_axil_bready_i) begin
                        wr_state_q <= video_pkg::WR_IDLE;
                    end
                end
                default: wr_state_q <= video_pkg::WR_IDLE;
            endcase
        end
    end

    assign s_axil_bvalid_o = (wr_state_q == video_pkg::WR_RESP);
    assign s_axil_bresp_o  = `AXIL_RESP_OKAY;

    // RD_DATA is the cycle the ram word arrives, RD_RESP holds it under stall
    always_ff @(posedge clk_cpu_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_state_q <= video_pkg::RD_IDLE;
        end else begin
            case (rd_state_q)
                video_pkg::RD_IDLE: begin
                    if (rd_accept) begin
                        rd_state_q <= video_pkg::RD_DATA;
                    end
                end
                video_pkg::RD_DATA: begin
                    if (s_axil_rready_i) begin
                        rd_state_q <= video_pkg::RD_IDLE;
                    end else begin
                        rd_state_q <= video_pkg::RD_RESP;
                    end
                end
                video_pkg::RD_RESP: begin
                    if (s_axil_rready_i) begin
                        rd_state_q <= video_pkg::RD_IDLE;
                    end
                end
                default: rd_state_q <= video_pkg::RD_IDLE;
            endcase
        end
    end

    // capture ram output on first response cycle
    always_ff @(posedge clk_cpu_i) begin
        if (rd_state_q == video_pkg::RD_DATA) begin
            rdata_q <= ram_rdata_i;
        end
    end

    assign s_axil_rvalid_o = (rd_state_q != video_pkg::RD_IDLE);
    assign s_axil_rdata_o  = (rd_state_q == video_pkg::RD_RESP) ? rdata_q : ram_rdata_i;
    assign s_axil_rresp_o  = `AXIL_RESP_OKAY;

endmodule

/* hw/video_macros.svh */
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// horizontal timing in pixel clocks
`define VID_H_ACTIVE 64
`define VID_H_FRONT  4
`define VID_H_SYNC   8
`define VID_H_BACK   4
`define VID_H_TOTAL  (`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK)

// vertical timing in lines
`define VID_V_ACTIVE 64
`define VID_V_FRONT  2
`define VID_V_SYNC   2
`define VID_V_BACK   2
`define VID_V_TOTAL  (`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK)

// axi response codes
`define AXIL_RESP_OKAY 2'b00

`endif

/* hw/video_pkg.sv */
package video_pkg;

    // cpu side
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [11:0] byte_addr_t;
    typedef logic [9:0]  word_addr_t;
    typedef logic [1:0]  resp_t;

    // rgb332
    typedef logic [7:0]  pixel_t;

    // raster position
    typedef logic [6:0]  hcount_t;
    typedef logic [6:0]  vcount_t;

    typedef enum logic [0:0] {
        WR_IDLE,
        WR_RESP
    } axil_wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_DATA,
        RD_RESP
    } axil_rd_state_t;

endpackage

/* hw/video_ram.sv */
module video_ram (
    // cpu port, word wide
    input  logic                  clk_cpu_i,
    input  video_pkg::word_addr_t cpu_addr_i,
    input  video_pkg::word_t      cpu_wdata_i,
    input  video_pkg::strb_t      cpu_wstrb_i,
    input  logic                  cpu_rd_en_i,
    output video_pkg::word_t      cpu_rdata_o,

    // pixel port, byte wide and read only
    input  logic                  clk_pxl_i,
    input  video_pkg::byte_addr_t pxl_addr_i,
    output video_pkg::pixel_t     pxl_data_o
);

    video_pkg::pixel_t mem [0:4095];

    // frame starts out black
    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = '0;
        end
    end

    // byte lane k lands at byte 4a+k
    always @(posedge clk_cpu_i) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (cpu_wstrb_i[lane]) begin
                mem[{cpu_addr_i, 2'(lane)}] <= cpu_wdata_i[8*lane +: 8];
            end
        end
    end

    // output holds between reads
    always_ff @(posedge clk_cpu_i) begin
        if (cpu_rd_en_i) begin
            cpu_rdata_o <= {
                mem[{cpu_addr_i, 2'd3}],
                mem[{cpu_addr_i, 2'd2}],
                mem[{cpu_addr_i, 2'd1}],
                mem[{cpu_addr_i, 2'd0}]
            };
        end
    end

    // read every pixel clock
    always_ff @(posedge clk_pxl_i) begin
        pxl_data_o <= mem[pxl_addr_i];
    end

endmodule

/* hw/video_scanout.sv */
module video_scanout (
    input  logic              clk_pxl_i,
    input  logic              pxl_rst_n_i,
    input  logic              active_i,
    input  logic              hsync_n_i,
    input  logic              vsync_n_i,
    input  video_pkg::pixel_t pixel_i,
    output video_pkg::pixel_t rgb_o,
    output logic              de_o,
    output logic              hsync_n_o,
    output logic              vsync_n_o
);

    // first stage lines up with the ram read
    logic active_q;
    logic hsync_n_q;
    logic vsync_n_q;

    always_ff @(posedge clk_pxl_i or negedge pxl_rst_n_i) begin
        if (!pxl_rst_n_i) begin
            active_q  <= 1'b0;
            hsync_n_q <= 1'b1;
            vsync_n_q <= 1'b1;
        end else begin
            active_q  <= active_i;
            hsync_n_q <= hsync_n_i;
            vsync_n_q <= vsync_n_i;
        end
    end

    // second stage drives the pins
    always_ff @(posedge clk_pxl_i or negedge pxl_rst_n_i) begin
        if (!pxl_rst_n_i) begin
            rgb_o     <= '0;
            de_o      <= 1'b0;
            hsync_n_o <= 1'b1;
            vsync_n_o <= 1'b1;
        end else begin
            // blank outside the visible area
            rgb_o     <= active_q ? pixel_i : '0;
            de_o      <= active_q;
            hsync_n_o <= hsync_n_q;
            vsync_n_o <= vsync_n_q;
        end
    end

endmodule

/* hw/video_subsystem_top.sv */
module video_subsystem_top (
    input  logic                  clk_cpu_i,
    input  logic                  rst_n_i,
    input  logic                  clk_pxl_i,
    input  logic                  pxl_rst_n_i,

    input  video_pkg::byte_addr_t s_axil_awaddr_i,
    input  logic                  s_axil_awvalid_i,
    output logic                  s_axil_awready_o,
    input  video_pkg::word_t      s_axil_wdata_i,
    input  video_pkg::strb_t      s_axil_wstrb_i,
    input  logic                  s_axil_wvalid_i,
    output logic                  s_axil_wready_o,
    output video_pkg::resp_t      s_axil_bresp_o,
    output logic                  s_axil_bvalid_o,
    input  logic                  s_axil_bready_i,
    input  video_pkg::byte_addr_t s_axil_araddr_i,
    input  logic                  s_axil_arvalid_i,
    output logic                  s_axil_arready_o,
    output video_pkg::word_t      s_axil_rdata_o,
    output video_pkg::resp_t      s_axil_rresp_o,
    output logic                  s_axil_rvalid_o,
    input  logic                  s_axil_rready_i,

    output video_pkg::pixel_t     pxl_rgb_o,
    output logic                  pxl_de_o,
    output logic                  pxl_hsync_n_o,
    output logic                  pxl_vsync_n_o
);

    video_pkg::word_addr_t ram_addr;
    video_pkg::word_t      ram_wdata;
    video_pkg::strb_t      ram_wstrb;
    logic                  ram_rd_en;
    video_pkg::word_t      ram_rdata;

    // pixel domain, early copies ahead of the ram latency
    video_pkg::byte_addr_t pxl_addr;
    video_pkg::pixel_t     pxl_data;
    logic                  early_active;
    logic                  early_hsync_n;
    logic                  early_vsync_n;

    video_axil_slave i_axil_slave (
        .clk_cpu_i        (clk_cpu_i),
        .rst_n_i          (rst_n_i),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .ram_addr_o       (ram_addr),
        .ram_wdata_o      (ram_wdata),
        .ram_wstrb_o      (ram_wstrb),
        .ram_rd_en_o      (ram_rd_en),
        .ram_rdata_i      (ram_rdata)
    );

    video_ram i_ram (
        .clk_cpu_i   (clk_cpu_i),
        .cpu_addr_i  (ram_addr),
        .cpu_wdata_i (ram_wdata),
        .cpu_wstrb_i (ram_wstrb),
        .cpu_rd_en_i (ram_rd_en),
        .cpu_rdata_o (ram_rdata),
        .clk_pxl_i   (clk_pxl_i),
        .pxl_addr_i  (pxl_addr),
        .pxl_data_o  (pxl_data)
    );

    video_timing i_timing (
        .clk_pxl_i   (clk_pxl_i),
        .pxl_rst_n_i (pxl_rst_n_i),
        .pxl_addr_o  (pxl_addr),
        .active_o    (early_active),
        .hsync_n_o   (early_hsync_n),
        .vsync_n_o   (early_vsync_n)
    );

    video_scanout i_scanout (
        .clk_pxl_i   (clk_pxl_i),
        .pxl_rst_n_i (pxl_rst_n_i),
        .active_i    (early_active),
        .hsync_n_i   (early_hsync_n),
        .vsync_n_i   (early_vsync_n),
        .pixel_i     (pxl_data),
        .rgb_o       (pxl_rgb_o),
        .de_o        (pxl_de_o),
        .hsync_n_o   (pxl_hsync_n_o),
        .vsync_n_o   (pxl_vsync_n_o)
    );

endmodule

/* hw/video_timing.sv */
`include "video_macros.svh"

module video_timing (
    input  logic                  clk_pxl_i,
    input  logic                  pxl_rst_n_i,
    output video_pkg::byte_addr_t pxl_addr_o,
    output logic                  active_o,
    output logic                  hsync_n_o,
    output logic                  vsync_n_o
);

    localparam video_pkg::hcount_t H_LAST =
        video_pkg::hcount_t'(`VID_H_TOTAL - 1);
    localparam video_pkg::hcount_t H_ACTIVE =
        video_pkg::hcount_t'(`VID_H_ACTIVE);
    localparam video_pkg::hcount_t H_SYNC_START =
        video_pkg::hcount_t'(`VID_H_ACTIVE + `VID_H_FRONT);
    localparam video_pkg::hcount_t H_SYNC_END =
        video_pkg::hcount_t'(`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC);

    localparam video_pkg::vcount_t V_LAST =
        video_pkg::vcount_t'(`VID_V_TOTAL - 1);
    localparam video_pkg::vcount_t V_ACTIVE =
        video_pkg::vcount_t'(`VID_V_ACTIVE);
    localparam video_pkg::vcount_t V_SYNC_START =
        video_pkg::vcount_t'(`VID_V_ACTIVE + `VID_V_FRONT);
    localparam video_pkg::vcount_t V_SYNC_END =
        video_pkg::vcount_t'(`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC);

    video_pkg::hcount_t hcount_q;
    video_pkg::vcount_t vcount_q;
    logic               line_end;

    assign line_end = (hcount_q == H_LAST);

    always_ff @(posedge clk_pxl_i or negedge pxl_rst_n_i) begin
        if (!pxl_rst_n_i) begin
            hcount_q <= '0;
            vcount_q <= '0;
        end else begin
            if (line_end) begin
                hcount_q <= '0;
                if (vcount_q == V_LAST) begin
                    vcount_q <= '0;
                end else begin
                    vcount_q <= vcount_q + 1'b1;
                end
            end else begin
                hcount_q <= hcount_q + 1'b1;
            end
        end
    end

    assign active_o  = (hcount_q < H_ACTIVE) && (vcount_q < V_ACTIVE);

    // sync pulses sit right after the front porches
    assign hsync_n_o = !((hcount_q >= H_SYNC_START) && (hcount_q < H_SYNC_END));
    assign vsync_n_o = !((vcount_q >= V_SYNC_START) && (vcount_q < V_SYNC_END));

    // byte y*64 + x, row of 64 makes this a plain concatenation
    assign pxl_addr_o = active_o ? {vcount_q[5:0], hcount_q[5:0]} : '0;

endmodule

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run; pass only if the pass line is printed
verilator --binary --timing --assert -f video_subsystem_top.f \
    --top-module video_subsystem_tb -o video_sim &&
./obj_dir/video_sim | tee /dev/stderr | grep -qF '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* testbench/video_subsystem_asserts.sv */
module video_subsystem_asserts (
    input logic                 clk_cpu_i,
    input logic                 rst_n_i,
    input logic                 clk_pxl_i,
    input logic                 pxl_rst_n_i,
    input logic                 s_axil_bvalid_o,
    input logic                 s_axil_bready_i,
    input logic                 s_axil_rvalid_o,
    input logic                 s_axil_rready_i,
    input video_pkg::word_t     s_axil_rdata_o,
    input logic                 s_axil_awready_o,
    input logic                 s_axil_arready_o,
    input logic                 pxl_de_o,
    input logic                 pxl_hsync_n_o,
    input logic                 pxl_vsync_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    bvalid_hold: assert property (@(posedge clk_cpu_i) disable iff (!rst_n_i)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk_cpu_i) disable iff (!rst_n_i)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o))
        else $error("rvalid or rdata changed before rready");

    // write wins the shared ram port
    ready_excl: assert property (@(posedge clk_cpu_i) disable iff (!rst_n_i)
        !(s_axil_awready_o && s_axil_arready_o))
        else $error("awready and arready high together");

    de_in_sync: assert property (@(posedge clk_pxl_i) disable iff (!pxl_rst_n_i)
        pxl_de_o |-> pxl_hsync_n_o && pxl_vsync_n_o)
        else $error("de high during a sync pulse");

endmodule

bind video_subsystem_top video_subsystem_asserts i_asserts (.*);

/* testbench/video_subsystem_tb.sv */
`include "video_macros.svh"

module video_subsystem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] OP_WR = 2'd0;
    localparam logic [1:0] OP_RD = 2'd1;
    localparam logic [1:0] OP_WR_RD = 2'd2;
    localparam int N_ROWS = 11;

    typedef struct packed {
        video_pkg::byte_addr_t addr;
        video_pkg::word_t      data;
        video_pkg::strb_t      strb;
        logic [1:0]            op;
        video_pkg::word_t      exp;
    } row_t;

    // address, data, strobe, operation, expected read word
    localparam row_t STIM [0:N_ROWS-1] = '{
        '{12'h000, 32'h11223344, 4'hf, OP_WR,    32'h00000000},
        '{12'h000, 32'h00000000, 4'h0, OP_RD,    32'h11223344},
        '{12'h000, 32'haabbccdd, 4'h5, OP_WR,    32'h00000000},
        '{12'h000, 32'h00000000, 4'h0, OP_RD,    32'h11bb33dd},
        '{12'h104, 32'hcafef00d, 4'hc, OP_WR,    32'h00000000},
        '{12'h107, 32'h00000000, 4'h0, OP_RD,    32'hcafe0000},
        '{12'h040, 32'h01020304, 4'hf, OP_WR_RD, 32'h01020304},
        '{12'hffc, 32'hdeadbeef, 4'h2, OP_WR,    32'h00000000},
        '{12'hffc, 32'h00000000, 4'h0, OP_RD,    32'h0000be00},
        '{12'h104, 32'h5a5a5a5a, 4'h3, OP_WR_RD, 32'hcafe5a5a},
        '{12'h040, 32'h00000000, 4'h0, OP_RD,    32'h01020304}
    };

    logic clk_cpu, rst_n, clk_pxl, pxl_rst_n;
    video_pkg::byte_addr_t awaddr, araddr;
    video_pkg::word_t wdata, rdata;
    video_pkg::strb_t wstrb;
    video_pkg::resp_t bresp, rresp;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    video_pkg::pixel_t rgb;
    logic de, hsync_n, vsync_n;
    video_pkg::pixel_t model [0:4095];
    logic [31:0] rng_state;

    video_subsystem_top i_dut (
        .clk_cpu_i(clk_cpu), .rst_n_i(rst_n), .clk_pxl_i(clk_pxl), .pxl_rst_n_i(pxl_rst_n),
        .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
        .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
        .s_axil_wready_o(wready), .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid),
        .s_axil_bready_i(bready), .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid),
        .s_axil_arready_o(arready), .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp),
        .s_axil_rvalid_o(rvalid), .s_axil_rready_i(rready),
        .pxl_rgb_o(rgb), .pxl_de_o(de), .pxl_hsync_n_o(hsync_n), .pxl_vsync_n_o(vsync_n)
    );

    always #2 clk_cpu = ~clk_cpu;
    always #3 clk_pxl = ~clk_pxl;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic fail_with(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input video_pkg::word_t got,
                              input video_pkg::word_t exp);
        if (got !== exp) begin
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_resp(input string name, input video_pkg::resp_t got);
        if (got !== `AXIL_RESP_OKAY) begin
            $display("error %s got 0x%h expected 0x%h", name, got, `AXIL_RESP_OKAY);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_pixel(input string name, input video_pkg::pixel_t got,
                               input video_pkg::pixel_t exp);
        if (got !== exp) begin
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    function automatic video_pkg::word_t model_word(input video_pkg::byte_addr_t addr);
        return {model[{addr[11:2], 2'd3}], model[{addr[11:2], 2'd2}],
                model[{addr[11:2], 2'd1}], model[{addr[11:2], 2'd0}]};
    endfunction

    task automatic model_write(input video_pkg::byte_addr_t addr, input video_pkg::word_t data,
                               input video_pkg::strb_t strb);
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                model[{addr[11:2], 2'(k)}] = data[8*k +: 8];
            end
        end
    endtask

    // one table row, both channels if asked, then responses with random stalls
    task automatic bus_op(input row_t row);
        logic aw_done, ar_done, aw_fire, ar_fire;
        video_pkg::word_t held;
        int stall;
        aw_done = (row.op == OP_RD);
        ar_done = (row.op == OP_WR);
        @(posedge clk_cpu);
        if (!aw_done) begin
            awaddr <= row.addr;
            wdata <= row.data;
            wstrb <= row.strb;
            awvalid <= 1'b1;
            wvalid <= 1'b1;
        end
        if (!ar_done) begin
            araddr <= row.addr;
            arvalid <= 1'b1;
        end
        while (!(aw_done && ar_done)) begin
            @(negedge clk_cpu);
            aw_fire = !aw_done && awready;
            ar_fire = !ar_done && arready;
            if (aw_fire) begin
                check_flag("wready", wready, 1'b1);
                model_write(row.addr, row.data, row.strb);
                aw_done = 1'b1;
            end
            if (ar_fire) begin
                ar_done = 1'b1;
            end
            @(posedge clk_cpu);
            if (aw_fire) begin
                awvalid <= 1'b0;
                wvalid <= 1'b0;
            end
            if (ar_fire) begin
                arvalid <= 1'b0;
            end
        end
        if (row.op != OP_RD) begin
            @(negedge clk_cpu);
            while (!bvalid) @(negedge clk_cpu);
            stall = int'(xorshift32() % 32'd8);
            repeat (stall) begin
                @(negedge clk_cpu);
                check_flag("bvalid", bvalid, 1'b1);
            end
            check_resp("bresp", bresp);
            @(posedge clk_cpu) bready <= 1'b1;
            @(posedge clk_cpu) bready <= 1'b0;
            @(negedge clk_cpu);
            check_flag("bvalid", bvalid, 1'b0);
        end
        if (row.op != OP_WR) begin
            @(negedge clk_cpu);
            while (!rvalid) @(negedge clk_cpu);
            held = rdata;
            check_word("rdata", rdata, row.exp);
            check_word("rdata", rdata, model_word(row.addr));
            stall = int'(xorshift32() % 32'd8);
            // second read of the same word must wait for the pending response
            @(posedge clk_cpu) arvalid <= 1'b1;
            repeat (stall) begin
                @(negedge clk_cpu);
                check_flag("rvalid", rvalid, 1'b1);
                check_word("rdata", rdata, held);
                check_flag("arready", arready, 1'b0);
            end
            check_resp("rresp", rresp);
            @(posedge clk_cpu) rready <= 1'b1;
            @(negedge clk_cpu);
            check_flag("arready", arready, 1'b0);
            @(posedge clk_cpu) rready <= 1'b0;
            @(negedge clk_cpu);
            check_flag("rvalid", rvalid, 1'b0);
            check_flag("arready", arready, 1'b1);
            @(posedge clk_cpu) arvalid <= 1'b0;
            @(negedge clk_cpu);
            check_flag("rvalid", rvalid, 1'b1);
            check_word("rdata", rdata, held);
            check_resp("rresp", rresp);
            @(posedge clk_cpu) rready <= 1'b1;
            @(posedge clk_cpu) rready <= 1'b0;
            @(negedge clk_cpu);
            check_flag("rvalid", rvalid, 1'b0);
        end
    endtask

    // one frame from the first de after vsync rises
    task automatic capture_frame();
        int x, y;
        x = 0;
        y = 0;
        @(negedge clk_pxl);
        while (vsync_n) @(negedge clk_pxl);
        while (!vsync_n) @(negedge clk_pxl);
        while (y < 64) begin
            if (de) begin
                check_pixel("pxl_rgb", rgb, model[video_pkg::byte_addr_t'(y * 64 + x)]);
                x++;
                if (x == 64) begin
                    x = 0;
                    y++;
                end
            end else begin
                if (x != 0) fail_with("de dropped in the middle of a visible line");
                check_pixel("pxl_rgb", rgb, 8'h00);
            end
            @(negedge clk_pxl);
        end
    endtask

    task automatic check_sync_timing();
        int n, lines;
        @(negedge clk_pxl);
        while (!hsync_n) @(negedge clk_pxl);
        while (hsync_n) @(negedge clk_pxl);
        n = 0;
        while (!hsync_n) begin
            n++;
            @(negedge clk_pxl);
        end
        check_word("hsync width", video_pkg::word_t'(n), 32'd8);
        while (hsync_n) begin
            n++;
            @(negedge clk_pxl);
        end
        check_word("hsync period", video_pkg::word_t'(n), 32'd80);
        // lines inside the pulse, then lines up to the next vsync fall
        while (vsync_n) @(negedge clk_pxl);
        lines = 0;
        while (!vsync_n) begin
            if (hsync_n) begin
                @(negedge clk_pxl);
                if (!hsync_n) lines++;
            end else begin
                @(negedge clk_pxl);
            end
        end
        check_word("vsync width", video_pkg::word_t'(lines), 32'd2);
        while (vsync_n) begin
            if (hsync_n) begin
                @(negedge clk_pxl);
                if (!hsync_n) lines++;
            end else begin
                @(negedge clk_pxl);
            end
        end
        check_word("lines per frame", video_pkg::word_t'(lines), 32'd70);
    endtask

    initial begin
        #(N_ROWS * 40 * 4 + 3 * 5600 * 6);
        $display("timeout, the run did not finish in time");
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        clk_cpu = 1'b0;
        clk_pxl = 1'b0;
        rst_n = 1'b0;
        pxl_rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rng_state = 32'd40;
        for (int i = 0; i < 4096; i++) model[i] = '0;
        repeat (16) begin
            @(negedge clk_cpu);
            check_flag("awready", awready, 1'b0);
            check_flag("wready", wready, 1'b0);
            check_flag("arready", arready, 1'b0);
            check_flag("bvalid", bvalid, 1'b0);
            check_flag("rvalid", rvalid, 1'b0);
            check_flag("pxl_de", de, 1'b0);
            check_flag("pxl_hsync_n", hsync_n, 1'b1);
            check_flag("pxl_vsync_n", vsync_n, 1'b1);
            check_pixel("pxl_rgb", rgb, 8'h00);
        end
        @(posedge clk_cpu);
        rst_n <= 1'b1;
        pxl_rst_n <= 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            bus_op(STIM[r]);
        end
        capture_frame();
        check_sync_timing();
        $display("** PASS **");
        $finish;
    end

endmodule

/* video_subsystem_top.f */
+incdir+hw
hw/video_pkg.sv
hw/video_ram.sv
hw/video_axil_slave.sv
hw/video_timing.sv
hw/video_scanout.sv
hw/video_subsystem_top.sv
testbench/video_subsystem_asserts.sv
testbench/video_subsystem_tb.sv
